// File: bfs.f
source/bfs_csr_pkg.sv
source/bfs_graph_pkg.sv
source/bfs_queue.sv
source/bfs_graph_mem.sv
source/bfs_csr.sv
source/bfs_core.sv
source/bfs_top.sv
test/bfs_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module bfs_tb -f bfs.f -o bfs_sim
	./obj_dir/bfs_sim | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/bfs_tb.sv
module bfs_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import bfs_csr_pkg::*;
  import bfs_graph_pkg::*;

  localparam int NUM_TESTS   = 10;
  localparam int TEST_CYCLES = 2000;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;
  localparam int MAX_NODES   = 8;
  localparam int MAX_NEIGH   = 7;

  logic        clk;
  logic        rst;
  csr_req_t    csr_req;
  mem_load_t   mem_load;
  csr_rsp_t    csr_rsp;

  logic [15:0] lfsr;
  int          cycles = 0;

  // Graph under test with neighbors kept as node indices
  int          node_count;
  int          neigh_count [MAX_NODES];
  int          neigh [MAX_NODES][MAX_NEIGH];
  node_id_t    node_addr [MAX_NODES];

  // Reference BFS results
  logic        reached [MAX_NODES];
  int          reach_count;

  bfs_top #(
    .QDEPTH    (64),
    .MEM_WORDS (256)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .csr_req  (csr_req),
    .mem_load (mem_load),
    .csr_rsp  (csr_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      stop_on_error($sformatf("timeout: search not finished after %0d cycles", CYCLE_LIMIT));
    end
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand_bits(8) % (hi - lo + 1));
  endfunction

  task automatic check_rsp(input string name, input csr_rsp_t exp, input csr_rsp_t act,
                           input bit cmp_data);
    if (act.valid !== exp.valid || act.error !== exp.error ||
        (cmp_data && act.rdata !== exp.rdata)) begin
      stop_on_error($sformatf(
        "mismatch %s: expected valid %0b error %0b rdata %h, actual valid %0b error %0b rdata %h",
        name, exp.valid, exp.error, exp.rdata, act.valid, act.error, act.rdata));
    end
  endtask

  task automatic check_status(input string name, input bfs_status_t exp,
                              input bfs_status_t act);
    if (act !== exp) begin
      stop_on_error($sformatf(
        "mismatch %s: expected overflow/done/found %b, actual overflow/done/found %b",
        name, exp, act));
    end
  endtask

  // One request strobe with the response sampled one cycle later
  task automatic csr_access(input logic wen, input csr_addr_t addr, input logic [31:0] wdata,
                            output csr_rsp_t rsp);
    @(posedge clk);
    #1;
    csr_req = '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    rsp = csr_rsp;
    csr_req.valid = 1'b0;
  endtask

  task automatic write_reg(input string name, input csr_addr_t addr, input logic [31:0] data);
    csr_rsp_t rsp;
    csr_access(1'b1, addr, data, rsp);
    check_rsp(name, '{valid: 1'b1, error: 1'b0, rdata: '0}, rsp, 1'b0);
  endtask

  task automatic read_check(input string name, input csr_addr_t addr, input logic [31:0] exp);
    csr_rsp_t rsp;
    csr_access(1'b0, addr, 32'd0, rsp);
    check_rsp(name, '{valid: 1'b1, error: 1'b0, rdata: exp}, rsp, 1'b1);
  endtask

  task automatic read_status(input string name, output bfs_status_t st);
    csr_rsp_t rsp;
    csr_access(1'b0, REG_STAT, 32'd0, rsp);
    check_rsp(name, '{valid: 1'b1, error: 1'b0, rdata: '0}, rsp, 1'b0);
    st = bfs_status_t'(rsp.rdata[2:0]);
  endtask

  task automatic write_word(input node_id_t addr, input logic [63:0] data);
    @(posedge clk);
    #1;
    mem_load = '{valid: 1'b1, addr: addr, data: data};
  endtask

  // Nobody points to the last node when it is kept isolated
  task automatic build_graph(input bit isolate);
    int n_pick;
    int addr;
    node_count = rand_range(2, MAX_NODES);
    n_pick     = isolate ? node_count - 1 : node_count;
    addr       = rand_range(0, 15);
    for (int i = 0; i < node_count; i++) begin
      node_addr[i]   = node_id_t'(addr);
      neigh_count[i] = (isolate && i == node_count - 1) ? 0 : rand_range(0, MAX_NEIGH);
      for (int j = 0; j < neigh_count[i]; j++) begin
        neigh[i][j] = rand_range(0, n_pick - 1);
      end
      addr = addr + 1 + (neigh_count[i] + 1) / 2;
    end
  endtask

  // Header beat then neighbor pairs with a zero pad on odd counts
  task automatic load_graph();
    node_hdr_t  hdr;
    node_pair_t pair;
    node_id_t   a;
    for (int i = 0; i < node_count; i++) begin
      hdr = '{zero_hi: '0, neigh_ct: 4'(neigh_count[i]), zero_lo: '0, marked: 1'b0};
      a   = node_addr[i];
      write_word(a, hdr);
      for (int j = 0; j < neigh_count[i]; j += 2) begin
        a          = a + 32'd1;
        pair.first = node_addr[neigh[i][j]];
        pair.second = (j + 1 < neigh_count[i]) ? node_addr[neigh[i][j + 1]] : '0;
        write_word(a, pair);
      end
    end
    @(posedge clk);
    #1;
    mem_load.valid = 1'b0;
  endtask

  task automatic run_model(input int root);
    int fifo [MAX_NODES];
    int rd;
    int wr;
    int cur;
    for (int i = 0; i < MAX_NODES; i++) begin
      reached[i] = 1'b0;
    end
    reached[root] = 1'b1;
    fifo[0]       = root;
    rd            = 0;
    wr            = 1;
    while (rd < wr) begin
      cur = fifo[rd];
      rd  = rd + 1;
      for (int j = 0; j < neigh_count[cur]; j++) begin
        if (!reached[neigh[cur][j]]) begin
          reached[neigh[cur][j]] = 1'b1;
          fifo[wr]               = neigh[cur][j];
          wr                     = wr + 1;
        end
      end
    end
    reach_count = wr;
  endtask

  task automatic run_search(input string name, input int root, input int targ,
                            input logic exp_found, input int exp_count);
    bfs_status_t st;
    write_reg($sformatf("%s root", name), REG_ROOT, node_addr[root]);
    write_reg($sformatf("%s target", name), REG_TARG, node_addr[targ]);
    write_reg($sformatf("%s start", name), REG_STAT, 32'd0);
    st = '0;
    while (!st.done) begin
      read_status($sformatf("%s poll", name), st);
    end
    check_status(name, '{overflow: 1'b0, done: 1'b1, found: exp_found}, st);
    read_check($sformatf("%s count", name), REG_COUNT, 32'(exp_count));
  endtask

  initial begin
    bfs_status_t st;
    csr_rsp_t    rsp;
    logic [31:0] val;
    int          root;
    int          targ;
    bit          isolate;

    lfsr     = 16'd99;
    rst      = 1'b1;
    csr_req  = '0;
    mem_load = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    check_rsp("reset rsp idle", '{valid: 1'b0, error: 1'b0, rdata: '0}, csr_rsp, 1'b0);
    read_status("reset status", st);
    check_status("reset status", '{overflow: 1'b0, done: 1'b1, found: 1'b0}, st);
    read_check("reset count", REG_COUNT, 32'd0);

    val = rand_bits(32);
    write_reg("root write", REG_ROOT, val);
    read_check("root readback", REG_ROOT, val);
    val = rand_bits(32);
    write_reg("target write", REG_TARG, val);
    read_check("target readback", REG_TARG, val);
    write_reg("count write", REG_COUNT, 32'hffff_ffff);
    read_check("count read only", REG_COUNT, 32'd0);
    csr_access(1'b0, 4'd9, 32'd0, rsp);
    check_rsp("bad address", '{valid: 1'b1, error: 1'b1, rdata: '0}, rsp, 1'b0);

    for (int t = 0; t < NUM_TESTS - 2; t++) begin
      isolate = (t % 3 == 2);
      build_graph(isolate);
      load_graph();
      if (isolate) begin
        root = rand_range(0, node_count - 2);
        targ = node_count - 1;
      end else begin
        root = rand_range(0, node_count - 1);
        targ = rand_range(0, node_count - 1);
      end
      run_model(root);
      run_search($sformatf("graph %0d", t), root, targ, reached[targ], reach_count);
      // Headers are all marked now so only the root is seen
      if (t % 2 == 1) begin
        run_search($sformatf("graph %0d rerun", t), root, targ, root == targ, 1);
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: source/bfs_top.sv
module bfs_top #(
  parameter int QDEPTH    = 64,
  parameter int MEM_WORDS = 256
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bfs_csr_pkg::csr_req_t    csr_req,
  input  bfs_graph_pkg::mem_load_t mem_load,
  output bfs_csr_pkg::csr_rsp_t    csr_rsp
);
  import bfs_csr_pkg::*;
  import bfs_graph_pkg::*;

  logic        start;
  node_id_t    root;
  node_id_t    target;
  bfs_status_t status;
  logic [31:0] visit_count;
  logic        q_clear;
  logic        q_pop;
  logic        q_empty;
  logic        q_dropped;
  enq_t        enq;
  node_pair_t  enq_data;
  node_id_t    q_head;
  node_id_t    fetch_addr;
  logic        mem_ready;
  logic        mem_busy;
  mem_beat_t   beat;
  mem_load_t   load_gated;

  // Graph can only be rewritten while no search runs
  always_comb begin
    load_gated       = mem_load;
    load_gated.valid = mem_load.valid & status.done;
  end

  bfs_csr u_csr (
    .clk         (clk),
    .rst         (rst),
    .req         (csr_req),
    .status      (status),
    .visit_count (visit_count),
    .rsp         (csr_rsp),
    .start       (start),
    .root        (root),
    .target      (target)
  );

  bfs_core u_core (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .root        (root),
    .target      (target),
    .q_empty     (q_empty),
    .q_head      (q_head),
    .q_dropped   (q_dropped),
    .mem_ready   (mem_ready),
    .mem_busy    (mem_busy),
    .beat        (beat),
    .q_clear     (q_clear),
    .enq         (enq),
    .enq_data    (enq_data),
    .q_pop       (q_pop),
    .fetch_addr  (fetch_addr),
    .status      (status),
    .visit_count (visit_count)
  );

  bfs_queue #(
    .QDEPTH (QDEPTH)
  ) u_queue (
    .clk      (clk),
    .rst      (rst),
    .clear    (q_clear),
    .enq      (enq),
    .enq_data (enq_data),
    .pop      (q_pop),
    .head     (q_head),
    .empty    (q_empty),
    .dropped  (q_dropped)
  );

  bfs_graph_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk        (clk),
    .rst        (rst),
    .load       (load_gated),
    .fetch      (q_pop),
    .fetch_addr (fetch_addr),
    .ready      (mem_ready),
    .busy       (mem_busy),
    .beat       (beat)
  );

endmodule

// File: source/bfs_core.sv
module bfs_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  bfs_graph_pkg::node_id_t   root,
  input  bfs_graph_pkg::node_id_t   target,
  input  logic                      q_empty,
  input  bfs_graph_pkg::node_id_t   q_head,
  input  logic                      q_dropped,
  input  logic                      mem_ready,
  input  logic                      mem_busy,
  input  bfs_graph_pkg::mem_beat_t  beat,
  output logic                      q_clear,
  output bfs_graph_pkg::enq_t       enq,
  output bfs_graph_pkg::node_pair_t enq_data,
  output logic                      q_pop,
  output bfs_graph_pkg::node_id_t   fetch_addr,
  output bfs_csr_pkg::bfs_status_t  status,
  output logic [31:0]               visit_count
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CLEAR,
    S_HEADER,
    S_NEIGH
  } state_t;

  state_t     state;
  state_t     state_nxt;
  logic [3:0] neigh_left;
  logic       root_pending;
  logic       hdr_beat;
  logic       hdr_unmarked;
  logic       has_neigh;
  logic       search_done;
  logic       last_pair;

  assign hdr_beat     = beat.valid & beat.first & (state == S_HEADER);
  assign hdr_unmarked = hdr_beat & ~beat.data.hdr.marked;
  assign has_neigh    = (beat.data.hdr.neigh_ct != 4'd0);
  assign search_done  = (state == S_HEADER) & q_empty & ~mem_busy;
  assign last_pair    = (neigh_left <= 4'd2);

  // Head goes to memory in the cycle it leaves the queue
  assign q_pop      = ~q_empty & mem_ready & ((state == S_HEADER) | (state == S_NEIGH));
  assign fetch_addr = q_head;
  assign q_clear    = (state == S_CLEAR);

  always_comb begin
    enq      = 2'b00;
    enq_data = beat.data.pair;
    case (state)
      S_CLEAR: begin
        enq            = 2'b01;
        enq_data.first = root;
      end
      S_NEIGH: begin
        // Odd tail, only the low word is a neighbor
        if (beat.valid) begin
          enq = (neigh_left == 4'd1) ? 2'b01 : 2'b11;
        end
      end
      default: begin
        enq = 2'b00;
      end
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_nxt = S_CLEAR;
        end
      end
      S_CLEAR: begin
        state_nxt = S_HEADER;
      end
      S_HEADER: begin
        if (hdr_unmarked & has_neigh) begin
          state_nxt = S_NEIGH;
        end else if (search_done) begin
          state_nxt = S_IDLE;
        end
      end
      S_NEIGH: begin
        if (beat.valid & last_pair) begin
          state_nxt = S_HEADER;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      neigh_left   <= 4'd0;
      root_pending <= 1'b0;
      status       <= '{overflow: 1'b0, done: 1'b1, found: 1'b0};
      visit_count  <= '0;
    end else begin
      state <= state_nxt;
      if ((state == S_IDLE) & start) begin
        status       <= '{overflow: 1'b0, done: 1'b0, found: 1'b0};
        visit_count  <= '0;
        root_pending <= 1'b1;
      end else begin
        if (q_pop & (q_head == target)) begin
          status.found <= 1'b1;
        end
        if (q_dropped) begin
          status.overflow <= 1'b1;
        end
        if ((state == S_HEADER) & (state_nxt == S_IDLE)) begin
          status.done <= 1'b1;
        end
        // Root always counts, even when marked by an earlier run
        if (hdr_beat & (~beat.data.hdr.marked | root_pending)) begin
          visit_count <= visit_count + 32'd1;
        end
        if (hdr_beat) begin
          root_pending <= 1'b0;
        end
      end
      if (hdr_unmarked) begin
        neigh_left <= beat.data.hdr.neigh_ct;
      end else if ((state == S_NEIGH) & beat.valid) begin
        neigh_left <= neigh_left - 4'd2;
      end
    end
  end

endmodule

// File: source/bfs_csr.sv
module bfs_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  bfs_csr_pkg::csr_req_t     req,
  input  bfs_csr_pkg::bfs_status_t  status,
  input  logic [31:0]               visit_count,
  output bfs_csr_pkg::csr_rsp_t     rsp,
  output logic                      start,
  output bfs_graph_pkg::node_id_t   root,
  output bfs_graph_pkg::node_id_t   target
);
  import bfs_csr_pkg::*;

  logic        wr_en;
  logic        addr_ok;
  logic [31:0] rd_mux;
  logic        rsp_valid;
  logic        rsp_error;
  logic [31:0] rsp_rdata;

  assign wr_en = req.valid & req.wen;

  // Status write kicks off a search
  assign start = wr_en & (req.addr == REG_STAT);

  always_comb begin
    addr_ok = 1'b1;
    rd_mux  = '0;
    case (req.addr)
      REG_STAT:  rd_mux = {29'd0, status};
      REG_ROOT:  rd_mux = root;
      REG_TARG:  rd_mux = target;
      REG_COUNT: rd_mux = visit_count;
      default:   addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en & (req.addr == REG_ROOT)) begin
      root <= req.wdata;
    end
    if (wr_en & (req.addr == REG_TARG)) begin
      target <= req.wdata;
    end
  end

  // Every request gets a response, writes included
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_error <= 1'b0;
    end else begin
      rsp_valid <= req.valid;
      rsp_error <= req.valid & ~addr_ok;
    end
  end

  always_ff @(posedge clk) begin
    rsp_rdata <= rd_mux;
  end

  assign rsp = '{valid: rsp_valid, error: rsp_error, rdata: rsp_rdata};

endmodule

// File: source/bfs_graph_mem.sv
module bfs_graph_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bfs_graph_pkg::mem_load_t load,
  input  logic                     fetch,
  input  bfs_graph_pkg::node_id_t  fetch_addr,
  output logic                     ready,
  output logic                     busy,
  output bfs_graph_pkg::mem_beat_t beat
);
  import bfs_graph_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  logic [63:0]   mem [MEM_WORDS];
  logic          pend;
  logic [3:0]    pairs_left;
  logic [AW-1:0] req_idx;
  logic [AW-1:0] rd_idx;
  graph_word_u   hdr_word;
  graph_word_u   hdr_marked;
  graph_word_u   rd_word;
  logic [4:0]    ct_round;
  logic [3:0]    hdr_pairs;
  logic          beat_valid;
  logic          beat_first;
  graph_word_u   beat_data;

  // Stage 1 holds the request address, stage 2 the outgoing beat
  assign hdr_word = mem[req_idx];
  assign rd_word  = mem[rd_idx];

  always_comb begin
    hdr_marked            = hdr_word;
    hdr_marked.hdr.marked = 1'b1;
  end

  // One pair beat per two neighbors, none for a marked node
  assign ct_round  = {1'b0, hdr_word.hdr.neigh_ct} + 5'd1;
  assign hdr_pairs = hdr_word.hdr.marked ? 4'd0 : ct_round[4:1];

  assign busy  = pend | (pairs_left != 4'd0);
  assign ready = ~busy;

  assign beat = '{valid: beat_valid, first: beat_first, data: beat_data};

  always_ff @(posedge clk) begin
    if (rst) begin
      pend       <= 1'b0;
      pairs_left <= 4'd0;
      beat_valid <= 1'b0;
      beat_first <= 1'b0;
    end else begin
      pend       <= fetch & ready;
      beat_valid <= pend | (pairs_left != 4'd0);
      beat_first <= pend;
      if (pend) begin
        pairs_left <= hdr_pairs;
      end else if (pairs_left != 4'd0) begin
        pairs_left <= pairs_left - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load.valid) begin
      mem[load.addr[AW-1:0]] <= load.data;
    end
    // Mark on the header read, the beat still carries the old flag
    if (pend & ~hdr_word.hdr.marked) begin
      mem[req_idx] <= hdr_marked;
    end
    if (fetch & ready) begin
      req_idx <= fetch_addr[AW-1:0];
    end
    if (pend) begin
      rd_idx    <= req_idx + AW'(1);
      beat_data <= hdr_word;
    end else begin
      if (pairs_left != 4'd0) begin
        rd_idx <= rd_idx + AW'(1);
      end
      beat_data <= rd_word;
    end
  end

endmodule

// File: source/bfs_queue.sv
module bfs_queue #(
  parameter int QDEPTH = 64
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear,
  input  bfs_graph_pkg::enq_t       enq,
  input  bfs_graph_pkg::node_pair_t enq_data,
  input  logic                      pop,
  output bfs_graph_pkg::node_id_t   head,
  output logic                      empty,
  output logic                      dropped
);
  import bfs_graph_pkg::*;

  localparam int AW = $clog2(QDEPTH);

  node_id_t      slots [QDEPTH];
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  logic [AW:0]   count;
  logic [AW-1:0] rd_base;
  logic [AW-1:0] wr_base;
  logic [AW-1:0] wr_base_nx;
  logic [AW:0]   cnt_base;
  logic [AW:0]   space;
  logic          do_pop;
  logic          acc_lo;
  logic          acc_hi;

  // Circular pointer advance by 0, 1 or 2
  function automatic logic [AW-1:0] wrap_add(input logic [AW-1:0] ptr, input logic [1:0] n);
    logic [AW+1:0] sum;
    sum = (AW+2)'(ptr) + (AW+2)'(n);
    if (sum >= (AW+2)'(QDEPTH)) begin
      sum = sum - (AW+2)'(QDEPTH);
    end
    return sum[AW-1:0];
  endfunction

  // Clear restarts from slot 0 and still takes the same-cycle enqueue
  always_comb begin
    rd_base    = clear ? '0 : rd_ptr;
    wr_base    = clear ? '0 : wr_ptr;
    cnt_base   = clear ? '0 : count;
    space      = (AW+1)'(QDEPTH) - cnt_base;
    do_pop     = pop & ~clear & (count != '0);
    acc_lo     = enq[0] & (space != '0);
    acc_hi     = enq[1] & (space > (AW+1)'(acc_lo));
    wr_base_nx = wrap_add(wr_base, 2'(acc_lo));
  end

  assign head    = slots[rd_ptr];
  assign empty   = (count == '0);
  assign dropped = (enq[0] & ~acc_lo) | (enq[1] & ~acc_hi);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= wrap_add(rd_base, {1'b0, do_pop});
      wr_ptr <= wrap_add(wr_base, 2'(acc_lo) + 2'(acc_hi));
      count  <= cnt_base + (AW+1)'(acc_lo) + (AW+1)'(acc_hi) - (AW+1)'(do_pop);
    end
  end

  // High word lands behind the low word when both are taken
  always_ff @(posedge clk) begin
    if (acc_lo) begin
      slots[wr_base] <= enq_data.first;
    end
    if (acc_hi) begin
      slots[acc_lo ? wr_base_nx : wr_base] <= enq_data.second;
    end
  end

endmodule

// File: source/bfs_graph_pkg.sv
package bfs_graph_pkg;

  // Node id is the word address of its header beat
  typedef logic [31:0] node_id_t;

  // Header view of a graph word
  typedef struct packed {
    logic [27:0] zero_hi;
    logic [3:0]  neigh_ct;
    logic [30:0] zero_lo;
    logic        marked;
  } node_hdr_t;

  // Neighbor view, first neighbor in the low word
  typedef struct packed {
    node_id_t second;
    node_id_t first;
  } node_pair_t;

  typedef union packed {
    node_hdr_t  hdr;
    node_pair_t pair;
  } graph_word_u;

  // One beat of a node record stream
  typedef struct packed {
    logic        valid;
    logic        first;
    graph_word_u data;
  } mem_beat_t;

  // Memory load port, one word per strobe
  typedef struct packed {
    logic        valid;
    node_id_t    addr;
    logic [63:0] data;
  } mem_load_t;

  // Bit 0 pushes the low word, bit 1 the high word
  typedef logic [1:0] enq_t;

endpackage

// File: source/bfs_csr_pkg.sv
package bfs_csr_pkg;

  typedef logic [3:0] csr_addr_t;

  // Register map, any other address answers with error
  localparam csr_addr_t REG_STAT  = 4'd0;
  localparam csr_addr_t REG_ROOT  = 4'd1;
  localparam csr_addr_t REG_TARG  = 4'd2;
  localparam csr_addr_t REG_COUNT = 4'd3;

  // Single-cycle request strobe
  typedef struct packed {
    logic        valid;
    logic        wen;
    csr_addr_t   addr;
    logic [31:0] wdata;
  } csr_req_t;

  // Response, one cycle after the request
  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } csr_rsp_t;

  // Read in the low bits of REG_STAT
  typedef struct packed {
    logic overflow;
    logic done;
    logic found;
  } bfs_status_t;

endpackage
